//--- src/nes_bus_pkg.sv
`default_nettype none

package nes_bus_pkg;

	// Bus payloads
	typedef logic [15:0] addr_t;    // CPU address
	typedef logic [7:0]  data_t;    // CPU data byte
	typedef logic [4:0]  joy_data_t; // Serial bits from one joypad port

	// Only PAL has the long CPU cycle
	typedef enum logic [1:0] {
		NTSC  = 2'd0,
		PAL   = 2'd1,
		DENDY = 2'd2
	} sys_type_t;

	// Master clock ratios
	localparam int CPU_DIV   = 12; // Master clocks per CPU cycle
	localparam int PPU_DIV   = 4;  // Master clocks per PPU tick
	localparam int PAL_GROUP = 5;  // CPU cycles per PAL stretch group

	// Fixed register addresses
	localparam addr_t OAM_DMA_ADDR    = 16'h4014; // Write starts sprite DMA
	localparam addr_t OAM_DATA_ADDR   = 16'h2004; // Sprite DMA target
	localparam addr_t APU_STATUS_ADDR = 16'h4015;
	localparam addr_t JOY1_ADDR       = 16'h4016;
	localparam addr_t JOY2_ADDR       = 16'h4017;

	// Region bounds, upper one exclusive
	localparam addr_t PPU_LO = 16'h2000;
	localparam addr_t PPU_HI = 16'h4000;
	localparam addr_t APU_LO = 16'h4000;
	localparam addr_t APU_HI = 16'h4018;

endpackage

`default_nettype wire

//--- src/cpu_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

// Master clock timeline, normal cycle
//   clk  0123456789AB
//   PPU  ---P---P---P
//   CPU  -----------C
// In the long PAL cycle the CPU divider sits on 0 through an extra tick

module cpu_clock_gen import nes_bus_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  sys_type_t sys_type,
	output logic      cpu_ce,      // One clock per CPU cycle
	output logic      ppu_ce,      // One clock per PPU tick
	output logic      cart_slot,   // Cartridge access tick
	output logic      ppu_rd_slot, // PPU register read tick
	output logic      ppu_wr_slot, // PPU register write tick
	output logic      odd_cycle,   // 1 == odd, 0 == even
	output logic      cpu_reset
);

	logic [3:0] div_cpu;       // Master clocks into the CPU cycle
	logic [1:0] div_ppu;       // Master clocks into the PPU tick
	logic [1:0] ppu_tick;      // PPU tick number since last cpu_ce
	logic [2:0] pal_count;     // Position in the PAL group
	logic       hold_reset;
	sys_type_t  last_sys_type;
	logic       stretch;
	logic       cpu_stall;
	logic       first_slot;

	assign cpu_ce = (div_cpu == 4'(CPU_DIV - 1));
	assign ppu_ce = (div_ppu == 2'(PPU_DIV - 1));

	// Last cycle of a PAL group runs one PPU tick long
	assign stretch   = (pal_count == 3'(PAL_GROUP - 1));
	assign cpu_stall = stretch && (ppu_tick == 2'd0); // Freeze CPU divider through tick 0

	// Slots move one tick later in the long cycle
	assign first_slot  = ppu_ce && (ppu_tick == {1'b0, stretch});
	assign cart_slot   = first_slot;      // Cart sees CPU data first
	assign ppu_wr_slot = first_slot;
	assign ppu_rd_slot = ppu_ce && (ppu_tick == (stretch ? 2'd2 : 2'd1));

	assign cpu_reset = reset || hold_reset; // Released at first CPU cycle

	always_ff @(posedge clk) begin
		if (reset) begin
			div_cpu       <= 4'd0;
			div_ppu       <= 2'd0;
			ppu_tick      <= 2'd0;
			pal_count     <= 3'd0;
			odd_cycle     <= 1'b1;
			hold_reset    <= 1'b1;
			last_sys_type <= sys_type;
		end else begin
			last_sys_type <= sys_type;

			if (!cpu_stall)
				div_cpu <= cpu_ce ? 4'd0 : div_cpu + 4'd1;
			div_ppu <= ppu_ce ? 2'd0 : div_ppu + 2'd1;

			// Tick numbering restarts with every CPU cycle
			if (cpu_ce)
				ppu_tick <= 2'd0;
			else if (ppu_ce)
				ppu_tick <= ppu_tick + 2'd1;

			if (cpu_ce) begin
				odd_cycle  <= !odd_cycle;
				hold_reset <= 1'b0;
				if (sys_type == PAL)
					pal_count <= stretch ? 3'd0 : pal_count + 3'd1; // Group of five
			end

			// New system type, start all dividers over
			if (sys_type != last_sys_type) begin
				div_cpu   <= 4'd0;
				div_ppu   <= 2'd0;
				ppu_tick  <= 2'd0;
				pal_count <= 3'd0;
			end
		end
	end

endmodule

`default_nettype wire

//--- src/oam_dmc_dma.sv
`timescale 1ns/10ps
`default_nettype none

// Sprite DMA reads on even cycles and writes OAM on odd cycles
// DMC fetch always lands on an even cycle and bumps the sprite read

module oam_dmc_dma import nes_bus_pkg::*; (
	input  logic  clk,
	input  logic  reset,
	input  logic  cpu_ce,
	input  logic  odd_cycle,
	input  logic  sprite_trigger, // CPU wrote the DMA page register
	input  logic  dmc_request,
	input  logic  cpu_rnw,        // CPU in a read cycle
	input  data_t cpu_wdata,      // Page number at trigger
	input  data_t read_data,      // Byte returned on the bus
	input  addr_t dmc_addr,
	output addr_t dma_addr,
	output logic  dma_enable,     // DMA owns the bus
	output logic  dma_read,
	output data_t dma_wdata,
	output logic  dmc_ack,
	output logic  pause_cpu
);

	localparam logic [1:0] SPR_IDLE = 2'b00;
	localparam logic [1:0] SPR_WAIT = 2'b01; // Paused, waiting for odd read cycle
	localparam logic [1:0] SPR_RUN  = 2'b11; // Bit 1 set while moving bytes

	logic [1:0] spr_state;
	logic       dmc_state;
	data_t      spr_page;
	data_t      spr_index;
	data_t      spr_byte;   // Source byte held for the OAM write
	logic [8:0] index_next; // Carry out ends the page

	assign index_next = {1'b0, spr_index} + 9'd1;

	always_ff @(posedge clk) begin
		if (reset) begin
			spr_state <= SPR_IDLE;
			dmc_state <= 1'b0;
		end else if (cpu_ce) begin
			if (!dmc_state && dmc_request && cpu_rnw && !odd_cycle)
				dmc_state <= 1'b1;      // Claim the next even cycle
			if (dmc_state && !odd_cycle)
				dmc_state <= 1'b0;

			if (sprite_trigger)
				spr_state <= SPR_WAIT;
			if (spr_state == SPR_WAIT && cpu_rnw && odd_cycle)
				spr_state <= SPR_RUN;
			if (spr_state[1] && !odd_cycle && dmc_state)
				spr_state <= SPR_WAIT; // Read lost to DMC, idle odd cycle follows
			if (spr_state[1] && odd_cycle && index_next[8])
				spr_state <= SPR_IDLE; // Index FF written
		end
	end

	always_ff @(posedge clk) begin
		if (cpu_ce) begin
			if (sprite_trigger) begin
				spr_page  <= cpu_wdata;
				spr_index <= 8'h00;
			end
			if (spr_state[1] && odd_cycle)
				spr_index <= index_next[7:0];
			if (spr_state[1] && !odd_cycle && !dmc_ack)
				spr_byte <= read_data; // End of the sprite read cycle
		end
	end

	assign dmc_ack    = dmc_state && !odd_cycle;
	assign dma_enable = dmc_ack || spr_state[1];
	assign dma_read   = !odd_cycle;
	assign dma_wdata  = spr_byte;
	assign pause_cpu  = spr_state[0] || dmc_request;

	assign dma_addr = dmc_ack    ? dmc_addr :
	                  !odd_cycle ? {spr_page, spr_index} :
	                               OAM_DATA_ADDR;

endmodule

`default_nettype wire

//--- src/bus_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module bus_arbiter import nes_bus_pkg::*; (
	// CPU side
	input  addr_t cpu_addr,
	input  data_t cpu_wdata,
	input  logic  cpu_rnw,
	// DMA side
	input  addr_t dma_addr,
	input  data_t dma_wdata,
	input  logic  dma_enable,
	input  logic  dma_read,
	// Timing
	input  logic  cart_slot,
	input  logic  ppu_rd_slot,
	input  logic  ppu_wr_slot,
	input  logic  cpu_ce,
	// Shared bus
	output addr_t bus_addr,
	output data_t bus_wdata,
	output logic  bus_read,
	output logic  bus_write,
	// Strobes and selects
	output logic  sprite_trigger,
	output logic  ppu_reg_read,
	output logic  ppu_reg_write,
	output logic  prg_read,
	output logic  prg_write,
	output logic  apu_cs,
	output logic  ppu_cs,
	output logic  joy1_cs,
	output logic  joy2_cs,
	output logic  status_cs
);

	// DMA wins whenever it asks
	assign bus_addr  = dma_enable ? dma_addr  : cpu_addr;
	assign bus_wdata = dma_enable ? dma_wdata : cpu_wdata;
	assign bus_read  = dma_enable ? dma_read  : cpu_rnw;
	assign bus_write = !bus_read;

	// Address map
	assign ppu_cs    = (bus_addr >= PPU_LO) && (bus_addr < PPU_HI); // 8 regs mirrored
	assign apu_cs    = (bus_addr >= APU_LO) && (bus_addr < APU_HI); // APU and I/O
	assign joy1_cs   = (bus_addr == JOY1_ADDR);
	assign joy2_cs   = (bus_addr == JOY2_ADDR);
	assign status_cs = (bus_addr == APU_STATUS_ADDR);

	// PPU register access once per CPU cycle, on its own tick
	assign ppu_reg_read  = ppu_cs && bus_read  && ppu_rd_slot;
	assign ppu_reg_write = ppu_cs && bus_write && ppu_wr_slot;

	// Cart strobes on the first tick with CPU data valid
	assign prg_read  = bus_read && cart_slot && !apu_cs && !ppu_cs;
	assign prg_write = bus_write && cart_slot;

	// Page register write from the CPU itself
	assign sprite_trigger = cpu_ce && !dma_enable && bus_write && (bus_addr == OAM_DMA_ADDR);

endmodule

`default_nettype wire

//--- src/cpu_data_bus.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_data_bus import nes_bus_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  logic      bus_read,
	input  logic      bus_write,
	input  data_t     bus_wdata,
	input  logic      apu_cs,
	input  logic      ppu_cs,
	input  logic      joy1_cs,
	input  logic      joy2_cs,
	input  logic      status_cs,
	input  joy_data_t joypad1_data,
	input  joy_data_t joypad2_data,
	input  data_t     ppu_dout,
	input  data_t     apu_status,
	input  data_t     prg_din,
	input  logic      prg_allow,    // Cart memory answers this address
	output data_t     cpu_din,
	output logic [2:0] joypad_out,  // Strobe bits to both ports
	output logic [1:0] joypad_clock // One per port, high during a read
);

	data_t open_bus; // Last value seen on the data bus

	// Read data by fixed priority
	always_comb begin
		if (reset) begin
			cpu_din = 8'h00;
		end else if (apu_cs) begin
			if (joy1_cs)
				cpu_din = {open_bus[7:5], joypad1_data}; // Upper bits float
			else if (joy2_cs)
				cpu_din = {open_bus[7:5], joypad2_data};
			else if (status_cs)
				cpu_din = apu_status;
			else
				cpu_din = open_bus;        // Write-only APU regs
		end else if (ppu_cs) begin
			cpu_din = ppu_dout;
		end else if (prg_allow) begin
			cpu_din = prg_din;
		end else begin
			cpu_din = open_bus;            // Nothing drives the bus
		end
	end

	// Bus capacitance keeps the last byte
	always_ff @(posedge clk) begin
		open_bus <= cpu_din;
	end

	// Strobe latch on the first port address
	always_ff @(posedge clk) begin
		if (reset)
			joypad_out <= 3'b000;
		else if (bus_write && joy1_cs)
			joypad_out <= bus_wdata[2:0];
	end

	// Shift clocks follow reads of each port
	assign joypad_clock = {joy2_cs && bus_read, joy1_cs && bus_read};

endmodule

`default_nettype wire

//--- src/nes_bus_top.sv
`timescale 1ns/10ps
`default_nettype none

module nes_bus_top import nes_bus_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  sys_type_t  sys_type,
	// CPU pins
	input  addr_t      cpu_addr,
	input  data_t      cpu_wdata,
	input  logic       cpu_rnw,
	output data_t      cpu_din,
	output logic       cpu_ce,
	output logic       ppu_ce,
	output logic       odd_cycle,
	output logic       cpu_reset,
	output logic       pause_cpu,   // CPU RDY, inverted
	// DMC channel of the APU
	input  logic       dmc_request,
	input  addr_t      dmc_addr,
	output logic       dmc_ack,
	// Read sources
	input  data_t      ppu_dout,
	input  data_t      apu_status,
	input  data_t      prg_din,
	input  logic       prg_allow,
	// Shared bus
	output addr_t      bus_addr,
	output data_t      bus_wdata,
	output logic       bus_read,
	output logic       bus_write,
	output logic       ppu_reg_read,
	output logic       ppu_reg_write,
	output logic       prg_read,
	output logic       prg_write,
	// Controller ports
	input  joy_data_t  joypad1_data,
	input  joy_data_t  joypad2_data,
	output logic [2:0] joypad_out,
	output logic [1:0] joypad_clock
);

	logic  cart_slot;
	logic  ppu_rd_slot;
	logic  ppu_wr_slot;
	addr_t dma_addr;
	data_t dma_wdata;
	logic  dma_enable;
	logic  dma_read;
	logic  sprite_trigger;
	logic  apu_cs;
	logic  ppu_cs;
	logic  joy1_cs;
	logic  joy2_cs;
	logic  status_cs;

	cpu_clock_gen u_clock_gen (
		.clk         (clk),
		.reset       (reset),
		.sys_type    (sys_type),
		.cpu_ce      (cpu_ce),
		.ppu_ce      (ppu_ce),
		.cart_slot   (cart_slot),
		.ppu_rd_slot (ppu_rd_slot),
		.ppu_wr_slot (ppu_wr_slot),
		.odd_cycle   (odd_cycle),
		.cpu_reset   (cpu_reset)
	);

	oam_dmc_dma u_dma (
		.clk            (clk),
		.reset          (reset),
		.cpu_ce         (cpu_ce),
		.odd_cycle      (odd_cycle),
		.sprite_trigger (sprite_trigger),
		.dmc_request    (dmc_request),
		.cpu_rnw        (cpu_rnw),
		.cpu_wdata      (cpu_wdata),
		.read_data      (cpu_din),      // Sprite source byte comes back here
		.dmc_addr       (dmc_addr),
		.dma_addr       (dma_addr),
		.dma_enable     (dma_enable),
		.dma_read       (dma_read),
		.dma_wdata      (dma_wdata),
		.dmc_ack        (dmc_ack),
		.pause_cpu      (pause_cpu)
	);

	bus_arbiter u_arbiter (
		.cpu_addr       (cpu_addr),
		.cpu_wdata      (cpu_wdata),
		.cpu_rnw        (cpu_rnw),
		.dma_addr       (dma_addr),
		.dma_wdata      (dma_wdata),
		.dma_enable     (dma_enable),
		.dma_read       (dma_read),
		.cart_slot      (cart_slot),
		.ppu_rd_slot    (ppu_rd_slot),
		.ppu_wr_slot    (ppu_wr_slot),
		.cpu_ce         (cpu_ce),
		.bus_addr       (bus_addr),
		.bus_wdata      (bus_wdata),
		.bus_read       (bus_read),
		.bus_write      (bus_write),
		.sprite_trigger (sprite_trigger),
		.ppu_reg_read   (ppu_reg_read),
		.ppu_reg_write  (ppu_reg_write),
		.prg_read       (prg_read),
		.prg_write      (prg_write),
		.apu_cs         (apu_cs),
		.ppu_cs         (ppu_cs),
		.joy1_cs        (joy1_cs),
		.joy2_cs        (joy2_cs),
		.status_cs      (status_cs)
	);

	cpu_data_bus u_data_bus (
		.clk          (clk),
		.reset        (reset),
		.bus_read     (bus_read),
		.bus_write    (bus_write),
		.bus_wdata    (bus_wdata),
		.apu_cs       (apu_cs),
		.ppu_cs       (ppu_cs),
		.joy1_cs      (joy1_cs),
		.joy2_cs      (joy2_cs),
		.status_cs    (status_cs),
		.joypad1_data (joypad1_data),
		.joypad2_data (joypad2_data),
		.ppu_dout     (ppu_dout),
		.apu_status   (apu_status),
		.prg_din      (prg_din),
		.prg_allow    (prg_allow),
		.cpu_din      (cpu_din),
		.joypad_out   (joypad_out),
		.joypad_clock (joypad_clock)
	);

endmodule

`default_nettype wire

//--- sim/tb_nes_bus.sv
`timescale 1ns/10ps
`default_nettype none

module tb_nes_bus import nes_bus_pkg::*; ();

	localparam int CLK_PERIOD  = 10;
	localparam int WATCHDOG_NS = 2000 * 16 * CLK_PERIOD; // 2000 CPU cycles at PAL length

	logic       clk, reset, cpu_rnw, dmc_request, prg_allow;
	logic       cpu_ce, ppu_ce, odd_cycle, cpu_reset, pause_cpu, dmc_ack;
	logic       bus_read, bus_write, ppu_reg_read, ppu_reg_write, prg_read, prg_write;
	sys_type_t  sys_type;
	addr_t      cpu_addr, dmc_addr, bus_addr;
	data_t      cpu_wdata, cpu_din, ppu_dout, apu_status, prg_din, bus_wdata;
	joy_data_t  joypad1_data, joypad2_data;
	logic [2:0] joypad_out;
	logic [1:0] joypad_clock;

	logic [31:0] lfsr;
	int          errors;
	int          checks;

	// Bus as seen on the last clock of the previous CPU cycle
	addr_t      s_addr;
	data_t      s_wdata, s_din;
	logic       s_read, s_write, s_ack, s_pause;
	logic [1:0] s_joyclk;
	data_t      wr_mask, rd_mask, prg_mask, prg_wr_mask; // Bit n = strobe on PPU tick n, bit 7 = off tick

	nes_bus_top dut (.*);

	// Cartridge model
	function automatic data_t mem_byte(input addr_t addr);
		return addr[7:0] ^ addr[15:8];
	endfunction

	assign prg_allow = (bus_addr >= 16'h8000); // Upper half only
	assign prg_din   = mem_byte(bus_addr);

	always #(CLK_PERIOD / 2) clk = !clk;

	task automatic check_data(input string name, input data_t got, input data_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_addr(input string name, input addr_t got, input addr_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_count(input string what, input int got, input int exp);
		checks++;
		if (got != exp) begin
			errors++;
			$display("wrong number of %s: %0d instead of %0d", what, got, exp);
		end
	endtask

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] v);
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v    = {v[30:0], lfsr[0]}; // One step per bit
		end
	endtask

	task automatic wait_cpu_ce();
		do begin
			@(negedge clk);
		end while (!cpu_ce);
	endtask

	task automatic align_cycle();
		wait_cpu_ce();
		@(posedge clk);
		#1;
	endtask

	// One CPU cycle, entered just after a cpu_ce edge
	task automatic run_cycle(input addr_t addr, input data_t wdata, input logic rnw);
		logic [2:0] tick;
		logic       done;
		cpu_addr    = addr;
		cpu_wdata   = wdata;
		cpu_rnw     = rnw;
		tick        = 3'd0;
		done        = 1'b0;
		wr_mask     = '0;
		rd_mask     = '0;
		prg_mask    = '0;
		prg_wr_mask = '0;
		while (!done) begin
			@(negedge clk);
			if (ppu_reg_write)
				wr_mask[ppu_ce ? tick : 3'd7] = 1'b1;
			if (ppu_reg_read)
				rd_mask[ppu_ce ? tick : 3'd7] = 1'b1;
			if (prg_read)
				prg_mask[ppu_ce ? tick : 3'd7] = 1'b1;
			if (prg_write)
				prg_wr_mask[ppu_ce ? tick : 3'd7] = 1'b1;
			if (ppu_ce)
				tick = tick + 3'd1;
			if (cpu_ce) begin
				s_addr   = bus_addr;
				s_wdata  = bus_wdata;
				s_din    = cpu_din;
				s_read   = bus_read;
				s_write  = bus_write;
				s_ack    = dmc_ack;
				s_pause  = pause_cpu;
				s_joyclk = joypad_clock;
				done     = 1'b1;
			end
		end
		@(posedge clk);
		#1;
	endtask

	// NTSC enables and the held CPU reset
	task automatic clock_test();
		int   k;
		int   first_ppu;
		logic seen;
		logic exp_odd;
		seen = 1'b0;
		while (!seen) begin
			@(negedge clk);
			check_bit("cpu_reset", cpu_reset, 1'b1);
			check_bit("odd_cycle", odd_cycle, 1'b1);
			seen = cpu_ce;
		end
		first_ppu = -1;
		exp_odd   = 1'b0;
		for (k = 1; k <= 48; k++) begin
			@(negedge clk);
			check_bit("cpu_reset", cpu_reset, 1'b0);
			check_bit("cpu_ce", cpu_ce, (k % 12) == 0);
			check_bit("odd_cycle", odd_cycle, exp_odd);
			if ((k % 12) == 0)
				exp_odd = !exp_odd; // Flips on the edge that ends the cycle
			if (first_ppu < 0) begin
				if (ppu_ce)
					first_ppu = k;
			end else begin
				check_bit("ppu_ce", ppu_ce, ((k - first_ppu) % 4) == 0);
			end
		end
		align_cycle();
	endtask

	task automatic decode_test();
		logic [31:0] r;
		run_cycle(16'h2001, 8'h5a, 1'b0);
		check_data("ppu_reg_write ticks", wr_mask, 8'h01); // Tick 0 only
		rand_bits(8, r);
		ppu_dout = r[7:0];
		run_cycle(16'h2002, 8'h00, 1'b1);
		check_data("cpu_din", s_din, r[7:0]);
		check_data("ppu_reg_read ticks", rd_mask, 8'h02);
		check_data("prg_read ticks", prg_mask, 8'h00);     // PPU range is not cart
		run_cycle(16'h9000, 8'h00, 1'b1);
		check_data("cpu_din", s_din, mem_byte(16'h9000));
		check_data("prg_read ticks", prg_mask, 8'h01);
		check_data("prg_write ticks", prg_wr_mask, 8'h00);
		run_cycle(16'hc000, 8'h3c, 1'b0);
		check_data("prg_write ticks", prg_wr_mask, 8'h01);
		check_data("prg_read ticks", prg_mask, 8'h00);
	endtask

	task automatic joypad_test();
		logic [31:0] r;
		addr_t       addr;
		data_t       prev;
		rand_bits(15, r);
		addr = {1'b1, r[14:0]};
		run_cycle(addr, 8'h00, 1'b1);              // Leaves a known byte on the bus
		prev = mem_byte(addr);
		rand_bits(5, r);
		joypad1_data = r[4:0];
		run_cycle(JOY1_ADDR, 8'h00, 1'b1);
		check_data("cpu_din", s_din, {prev[7:5], r[4:0]});
		check_bit("joypad_clock[0]", s_joyclk[0], 1'b1);
		check_bit("joypad_clock[1]", s_joyclk[1], 1'b0);
		rand_bits(8, r);
		run_cycle(JOY1_ADDR, r[7:0], 1'b0);
		check_data("joypad_out", {5'b0, joypad_out}, {5'b0, r[2:0]});
		check_bit("joypad_clock[0]", s_joyclk[0], 1'b0); // No shift on a write
	endtask

	// Page write, then 256 OAM writes, optionally with one DMC fetch stolen
	task automatic sprite_dma_test(input logic with_dmc);
		logic [31:0] r;
		data_t       page;
		data_t       exp_index;
		addr_t       last_rd;
		addr_t       dmc_a;
		int          writes;
		int          acks;
		int          cycle;
		int          dmc_at;
		rand_bits(7, r);
		page = {1'b1, r[6:0]};                     // Source in cart space
		rand_bits(7, r);
		dmc_at = 20 + int'(r[6:0]);
		rand_bits(14, r);
		dmc_a     = {2'b11, r[13:0]};
		exp_index = 8'h00;
		last_rd   = '0;
		writes    = 0;
		acks      = 0;
		cycle     = 0;
		run_cycle(OAM_DMA_ADDR, page, 1'b0);
		check_bit("pause_cpu", pause_cpu, 1'b1);
		while (writes < 256 || (with_dmc && acks == 0)) begin
			if (with_dmc && cycle == dmc_at) begin
				dmc_addr    = dmc_a;
				dmc_request = 1'b1;
			end
			run_cycle(16'h0123, 8'h00, 1'b1);      // Halted CPU keeps reading
			if (s_ack) begin
				acks++;
				check_addr("bus_addr", s_addr, dmc_a);
				check_bit("bus_read", s_read, 1'b1);
				dmc_request = 1'b0;                // APU drops it once served
			end else if (s_read && s_addr[15:8] == page) begin
				last_rd = s_addr;
			end
			if (s_write && s_addr == OAM_DATA_ADDR) begin
				check_addr("sprite source", last_rd, {page, exp_index});
				check_data("bus_wdata", s_wdata, page ^ exp_index);
				exp_index = exp_index + 8'h01;
				writes++;
			end
			cycle++;
		end
		check_count("DMC acknowledge cycles", acks, with_dmc ? 1 : 0);
		@(negedge clk);
		check_bit("pause_cpu", pause_cpu, 1'b0);
		align_cycle();
	endtask

	// DMC fetch on its own, CPU held only by the request
	task automatic dmc_test();
		logic [31:0] r;
		int          n;
		int          acks;
		rand_bits(14, r);
		dmc_addr    = {2'b11, r[13:0]};
		dmc_request = 1'b1;
		acks        = 0;
		for (n = 0; n < 4 && acks == 0; n++) begin   // Next even cycle after an even read
			run_cycle(16'h0123, 8'h00, 1'b1);
			check_bit("pause_cpu", s_pause, 1'b1);
			if (s_ack) begin
				acks++;
				check_addr("bus_addr", s_addr, dmc_addr);
				check_bit("bus_read", s_read, 1'b1);
			end
		end
		dmc_request = 1'b0;
		check_count("DMC acknowledge cycles", acks, 1);
		run_cycle(16'h0123, 8'h00, 1'b1);
		check_bit("pause_cpu", s_pause, 1'b0);
		check_bit("dmc_ack", s_ack, 1'b0);
	endtask

	// Five CPU cycles per 64 clocks once the group restarts
	task automatic pal_test();
		int   gap;
		int   count;
		int   w;
		logic found;
		sys_type = PAL;
		wait_cpu_ce();
		gap   = 0;
		found = 1'b0;
		while (!found) begin
			@(negedge clk);
			gap++;
			if (cpu_ce) begin
				found = (gap == 16); // End of the long cycle
				gap   = 0;
			end
		end
		for (w = 0; w < 2; w++) begin
			count = 0;
			repeat (64) begin
				@(negedge clk);
				if (cpu_ce)
					count++;
			end
			check_count("CPU cycles in a PAL group", count, 5);
			check_bit("cpu_ce", cpu_ce, 1'b1);
		end
	endtask

	initial begin
		lfsr         = 32'ha9da_4a05;
		errors       = 0;
		checks       = 0;
		clk          = 1'b0;
		reset        = 1'b1;
		sys_type     = NTSC;
		cpu_addr     = 16'h2001;  // PPU register write held through reset
		cpu_wdata    = '0;
		cpu_rnw      = 1'b0;
		dmc_request  = 1'b0;
		dmc_addr     = '0;
		ppu_dout     = 8'hff;
		apu_status   = '0;
		joypad1_data = '0;
		joypad2_data = '0;
		repeat (9) @(posedge clk);
		@(negedge clk);
		check_bit("cpu_reset", cpu_reset, 1'b1);
		check_bit("pause_cpu", pause_cpu, 1'b0);
		check_bit("dmc_ack", dmc_ack, 1'b0);
		check_data("cpu_din", cpu_din, 8'h00);
		check_data("joypad_out", {5'b0, joypad_out}, 8'h00);
		check_bit("ppu_reg_write", ppu_reg_write, 1'b0);
		check_bit("prg_write", prg_write, 1'b0);
		@(posedge clk);
		#1;
		reset = 1'b0;
		clock_test();
		decode_test();
		joypad_test();
		sprite_dma_test(1'b0);
		sprite_dma_test(1'b1);
		dmc_test();
		pal_test();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
		$display("checks: %0d, errors: %0d", checks, errors + 1);
		$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
src/nes_bus_pkg.sv
src/cpu_clock_gen.sv
src/oam_dmc_dma.sv
src/bus_arbiter.sv
src/cpu_data_bus.sv
src/nes_bus_top.sv
sim/tb_nes_bus.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --timescale 1ns/10ps --top-module tb_nes_bus \
	-f verilog.f -o tb_nes_bus_sim > build.log 2>&1 \
	|| { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/tb_nes_bus_sim > sim.log 2>&1
cat sim.log
grep -q "^All tests passed$" sim.log && exit 0 || exit 1
